// ==== dmi_cdc.sv ====
// clock crossing of the dmi request bus into the system clock with single issue per valid level
`timescale 1ns/10ps
`default_nettype none

module dmi_cdc (
    input  wire logic          i_clk,
    input  wire logic          i_nrst,
    input  wire dmi_pkg::dmi_bus_t i_bus,
    input  wire logic          i_ready,
    output dmi_pkg::dmi_req_t  o_req,
    output logic               o_req_valid,
    output logic               o_hardreset
);

    import dmi_pkg::*;

    // two synchronizer stages over the whole bus
    // the request fields are already stable when the valid bit rises, so they settle together
    dmi_bus_t l1_q;
    dmi_bus_t l2_q;

    // request presented to the register block
    dmi_req_t req_q;
    logic     req_valid_q;

    // set once the register block took the request for the current valid level
    logic     req_accepted_q;

    // a new issue needs a synchronized valid, nothing in flight and no earlier acceptance
    logic     issue;
    logic     accept;

    assign issue  = l2_q.valid && !req_valid_q && !req_accepted_q;
    assign accept = l2_q.valid && req_valid_q && i_ready;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            l1_q           <= '0;
            l2_q           <= '0;
            req_q          <= '0;
            req_valid_q    <= 1'b0;
            req_accepted_q <= 1'b0;
        end else begin
            l1_q <= i_bus;
            l2_q <= l1_q;

            if (issue) begin
                req_valid_q <= 1'b1;
                req_q       <= l2_q.req;
            end else if (i_ready) begin
                // drops the cycle after the handshake, otherwise it holds under back-pressure
                req_valid_q <= 1'b0;
            end

            if (accept) begin
                req_accepted_q <= 1'b1;
            end else if (!l2_q.valid) begin
                // the test clock side has captured, so the next valid level is a new request
                req_accepted_q <= 1'b0;
            end
        end
    end

    assign o_req       = req_q;
    assign o_req_valid = req_valid_q;
    // hardreset is a level and goes straight out of the second stage
    assign o_hardreset = l2_q.hardreset;

    // a request waiting for ready must not change or vanish
    a_hold_under_backpressure: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        (o_req_valid && !i_ready) |=> (o_req_valid && $stable(o_req))
    );

endmodule

`default_nettype wire

// ==== dmi_cfg.svh ====
// debug transport configuration constants shared by the package and the register block
`ifndef DMI_CFG_SVH
`define DMI_CFG_SVH

// width of the dmi address field carried in every request
`define DMI_ABITS 7

// number of 32-bit data registers in the register block
`define DMI_NDATA 8

// address of data register 0, the others follow contiguously
`define DMI_DATA_BASE 'h04

// address of the read-only accepted-request counter
`define DMI_CNT_ADDR 'h11

// i_clk cycles for which ready stays low after an accepted access
`define DMI_BUSY_CYCLES 3

`endif

// ==== dmi_pkg.sv ====
// shared types for the dmi request, response, shift word and clock crossing bus
`default_nettype none

`include "dmi_cfg.svh"

package dmi_pkg;

    // operation field of a dmi request, encoding follows the riscv debug spec
    typedef enum logic [1:0] {
        DMI_OP_NOP   = 2'd0,
        DMI_OP_READ  = 2'd1,
        DMI_OP_WRITE = 2'd2
    } dmi_op_e;

    // status field of a dmi response, 1 and 3 are not produced here
    typedef enum logic [1:0] {
        DMI_STATUS_OK     = 2'd0,
        DMI_STATUS_FAILED = 2'd2
    } dmi_status_e;

    // request view, op sits in the low bits so it leaves the shift register first
    typedef struct packed {
        logic [`DMI_ABITS-1:0] addr;
        logic [31:0]           data;
        dmi_op_e               op;
    } dmi_req_t;

    // response view, pad lines the data and status up with the request fields
    typedef struct packed {
        logic [`DMI_ABITS-1:0] pad;
        logic [31:0]           data;
        dmi_status_e           status;
    } dmi_rsp_t;

    // one shift word, read as a request at update and written as a response at capture
    typedef union packed {
        dmi_req_t req;
        dmi_rsp_t rsp;
    } dmi_shift_u;

    // levels that travel from the test clock domain into the system clock domain
    typedef struct packed {
        logic     hardreset;
        dmi_req_t req;
        logic     valid;
    } dmi_bus_t;

endpackage

`default_nettype wire

// ==== dmi_regs.sv ====
// debug register block with data registers, accepted request counter and busy back-pressure
`timescale 1ns/10ps
`default_nettype none

`include "dmi_cfg.svh"

module dmi_regs (
    input  wire logic          i_clk,
    input  wire logic          i_nrst,
    input  wire dmi_pkg::dmi_req_t i_req,
    input  wire logic          i_req_valid,
    input  wire logic          i_hardreset,
    output logic               o_ready,
    output dmi_pkg::dmi_rsp_t  o_rsp,
    output logic               o_rsp_valid
);

    import dmi_pkg::*;

    localparam int IDX_W  = $clog2(`DMI_NDATA);
    localparam int BUSY_W = $clog2(`DMI_BUSY_CYCLES + 1);

    logic [31:0]             data_q [`DMI_NDATA];
    // counts every accepted request whatever its address
    logic [31:0]             cnt_q;
    logic [BUSY_W-1:0]       busy_q;
    dmi_rsp_t                rsp_q;
    logic                    rsp_valid_q;

    // address decode of the current request
    logic [`DMI_ABITS-1:0]   offset;
    logic [IDX_W-1:0]        idx;
    logic                    hit_data;
    logic                    hit_cnt;
    logic [31:0]             rd_data;
    logic                    accept;

    assign offset   = i_req.addr - `DMI_ABITS'(`DMI_DATA_BASE);
    assign idx      = offset[IDX_W-1:0];
    assign hit_data = (i_req.addr >= `DMI_ABITS'(`DMI_DATA_BASE)) && (offset < `DMI_NDATA);
    assign hit_cnt  = (i_req.addr == `DMI_ABITS'(`DMI_CNT_ADDR));

    // the counter answers with its value before this access is counted
    // unmapped addresses answer with zero
    always_comb begin
        if (hit_data) begin
            rd_data = data_q[idx];
        end else if (hit_cnt) begin
            rd_data = cnt_q;
        end else begin
            rd_data = '0;
        end
    end

    // ready while no access is in its busy window and no hardreset is asserted
    assign o_ready = (busy_q == '0) && !i_hardreset;
    assign accept  = i_req_valid && o_ready;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            data_q      <= '{default: '0};
            cnt_q       <= '0;
            busy_q      <= '0;
            rsp_q       <= '0;
            rsp_valid_q <= 1'b0;
        end else if (i_hardreset) begin
            // debug hardreset puts the whole block back to its reset state every cycle
            data_q      <= '{default: '0};
            cnt_q       <= '0;
            busy_q      <= '0;
            rsp_q       <= '0;
            rsp_valid_q <= 1'b0;
        end else begin
            if (busy_q != '0) begin
                busy_q <= busy_q - 1'b1;
            end

            if (accept) begin
                busy_q      <= BUSY_W'(`DMI_BUSY_CYCLES);
                cnt_q       <= cnt_q + 32'd1;
                rsp_valid_q <= 1'b1;
                rsp_q.pad   <= '0;
                rsp_q.data  <= rd_data;
                // a write to the counter is allowed but has no effect
                rsp_q.status <= (hit_data || hit_cnt) ? DMI_STATUS_OK : DMI_STATUS_FAILED;
                if ((i_req.op == DMI_OP_WRITE) && hit_data) begin
                    data_q[idx] <= i_req.data;
                end
            end
        end
    end

    assign o_rsp       = rsp_q;
    assign o_rsp_valid = rsp_valid_q;

    // the response level stays up once given, only a hardreset takes it away
    a_rsp_valid_sticky: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        $fell(o_rsp_valid) |-> $past(i_hardreset)
    );

endmodule

`default_nettype wire

// ==== dmi_top.sv ====
// debug transport top joining the tck shift register, the clock crossing and the register block
`timescale 1ns/10ps
`default_nettype none

module dmi_top (
    input  wire logic i_clk,
    input  wire logic i_nrst,
    input  wire logic i_tck,
    input  wire logic i_tdi,
    input  wire logic i_shift,
    input  wire logic i_capture,
    input  wire logic i_update,
    input  wire logic i_hardreset,
    output logic      o_tdo
);

    import dmi_pkg::*;

    // tck domain levels heading into the system clock domain
    dmi_bus_t bus;

    // system clock side request and its handshake
    dmi_req_t req;
    logic     req_valid;
    logic     ready;
    logic     hardreset;

    // response level returning to the tck domain
    dmi_rsp_t rsp;
    logic     rsp_valid;

    dtm_shift i_dtm_shift (
        .i_tck       (i_tck),
        .i_nrst      (i_nrst),
        .i_tdi       (i_tdi),
        .i_shift     (i_shift),
        .i_capture   (i_capture),
        .i_update    (i_update),
        .i_hardreset (i_hardreset),
        .i_rsp       (rsp),
        .i_rsp_valid (rsp_valid),
        .o_tdo       (o_tdo),
        .o_bus       (bus)
    );

    dmi_cdc i_dmi_cdc (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_bus       (bus),
        .i_ready     (ready),
        .o_req       (req),
        .o_req_valid (req_valid),
        .o_hardreset (hardreset)
    );

    dmi_regs i_dmi_regs (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_req       (req),
        .i_req_valid (req_valid),
        .i_hardreset (hardreset),
        .o_ready     (ready),
        .o_rsp       (rsp),
        .o_rsp_valid (rsp_valid)
    );

endmodule

`default_nettype wire

// ==== dtm_shift.sv ====
// test clock side dmi data register that shifts, issues a held request and captures the answer
`timescale 1ns/10ps
`default_nettype none

module dtm_shift (
    input  wire logic              i_tck,
    input  wire logic              i_nrst,
    input  wire logic              i_tdi,
    input  wire logic              i_shift,
    input  wire logic              i_capture,
    input  wire logic              i_update,
    input  wire logic              i_hardreset,
    input  wire dmi_pkg::dmi_rsp_t i_rsp,
    input  wire logic              i_rsp_valid,
    output logic                   o_tdo,
    output dmi_pkg::dmi_bus_t      o_bus
);

    import dmi_pkg::*;

    // the single shift word seen through either view
    dmi_shift_u shift_q;

    // request level handed to the crossing, constant while valid_q is high
    dmi_req_t   req_q;
    logic       valid_q;
    logic       hardreset_q;

    // two flops that bring the response valid level into the tck domain
    logic [1:0] rsp_sync_q;

    // a read or write op is the only thing that starts a transfer
    logic       upd_is_access;

    assign upd_is_access = (shift_q.req.op == DMI_OP_READ) ||
                           (shift_q.req.op == DMI_OP_WRITE);

    always_ff @(posedge i_tck or negedge i_nrst) begin
        if (!i_nrst) begin
            shift_q     <= '0;
            req_q       <= '0;
            valid_q     <= 1'b0;
            hardreset_q <= 1'b0;
            rsp_sync_q  <= '0;
        end else begin
            rsp_sync_q  <= {rsp_sync_q[0], i_rsp_valid};
            // hardreset is a plain level and crosses without any handshake
            hardreset_q <= i_hardreset;

            if (i_capture) begin
                // the response data is stable long before its synchronized valid shows up
                if (rsp_sync_q[1]) begin
                    shift_q.rsp <= i_rsp;
                end else begin
                    shift_q.rsp <= '{pad: '0, data: '0, status: DMI_STATUS_FAILED};
                end
                // capture ends the transfer so the crossing may accept a new level
                valid_q <= 1'b0;
            end else if (i_shift) begin
                // lsb goes out on tdo, tdi enters at the top
                shift_q <= {i_tdi, shift_q[$bits(dmi_shift_u)-1:1]};
            end else if (i_update && !valid_q) begin
                // fields are only taken while idle so they never move under a high valid
                req_q <= shift_q.req;
                if (upd_is_access) begin
                    valid_q <= 1'b1;
                end
            end
        end
    end

    assign o_tdo = shift_q[0];

    assign o_bus.hardreset = hardreset_q;
    assign o_bus.req       = req_q;
    assign o_bus.valid     = valid_q;

    // the decoded tap strobes come from one tap state, so at most one is high
    a_strobe_onehot: assert property (
        @(posedge i_tck) disable iff (!i_nrst)
        $onehot0({i_capture, i_shift, i_update})
    );

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+.
dmi_pkg.sv
dtm_shift.sv
dmi_cdc.sv
dmi_regs.sv
dmi_top.sv
tb_dmi_top.sv

// ==== tb_dmi_top.sv ====
// self-checking testbench for the debug transport with lfsr stimulus and a register model
`timescale 1ns/10ps
`default_nettype none

`include "dmi_cfg.svh"

module tb_dmi_top;

    localparam int CLK_PERIOD   = 4;
    localparam int TCK_PERIOD   = 8 * CLK_PERIOD;
    localparam int RESET_CYCLES = 16;
    localparam int N_RANDOM     = 200;
    localparam int N_UNMAPPED   = 16;
    // random and unmapped accesses are each followed by a counter read
    localparam int N_ACCESSES   = 1 + `DMI_NDATA + 2 * N_RANDOM + 2 * N_UNMAPPED
                                  + `DMI_NDATA + 1 + `DMI_NDATA;
    localparam int TIMEOUT_NS   = N_ACCESSES * 100 * TCK_PERIOD + RESET_CYCLES * CLK_PERIOD;

    // dmi op and status encodings
    localparam logic [1:0] OP_NOP    = 2'd0;
    localparam logic [1:0] OP_READ   = 2'd1;
    localparam logic [1:0] OP_WRITE  = 2'd2;
    localparam logic [1:0] ST_OK     = 2'd0;
    localparam logic [1:0] ST_FAILED = 2'd2;

    logic i_clk;
    logic i_nrst;
    logic i_tck;
    logic i_tdi;
    logic i_shift;
    logic i_capture;
    logic i_update;
    logic i_hardreset;
    logic o_tdo;

    logic [15:0] lfsr_q;
    int          errors;
    int          checks;

    // reference copy of the register block
    logic [31:0] model_data [`DMI_NDATA];
    logic [31:0] model_cnt;

    dmi_top i_dmi_top (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_tck       (i_tck),
        .i_tdi       (i_tdi),
        .i_shift     (i_shift),
        .i_capture   (i_capture),
        .i_update    (i_update),
        .i_hardreset (i_hardreset),
        .o_tdo       (o_tdo)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // stops a stuck run, the budget is generous per access
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the tests did not complete within %0d ns", TIMEOUT_NS);
        $display("ERRORS FOUND");
        $finish;
    end

    // 16-bit fibonacci lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit taken
    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s expected %08h actual %08h", name, exp, act);
        end
    endtask

    // one tck period, strobes are set up by the caller while tck is low
    task automatic tck_pulse();
        repeat (4) @(posedge i_clk);
        #1;
        i_tck = 1'b1;
        repeat (4) @(posedge i_clk);
        #1;
        i_tck = 1'b0;
    endtask

    // lsb first, tdo is read before the edge that shifts it out
    task automatic shift_word(input logic [40:0] din, output logic [40:0] dout);
        for (int i = 0; i < 41; i++) begin
            dout[i] = o_tdo;
            i_shift = 1'b1;
            i_tdi   = din[i];
            tck_pulse();
        end
        i_shift = 1'b0;
        i_tdi   = 1'b0;
    endtask

    task automatic dmi_access(input logic [1:0] op, input logic [`DMI_ABITS-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic [1:0] status);
        logic [40:0] unused;
        logic [40:0] rsp;
        shift_word({addr, wdata, op}, unused);
        i_update = 1'b1;
        tck_pulse();
        i_update = 1'b0;
        // three idle tck periods leave far more than 12 i_clk cycles for the round trip
        repeat (3) tck_pulse();
        i_capture = 1'b1;
        tck_pulse();
        i_capture = 1'b0;
        shift_word({`DMI_ABITS'(0), 32'h0, OP_NOP}, rsp);
        // response layout is pad, data, status from the top
        rdata  = rsp[33:2];
        status = rsp[1:0];
    endtask

    // predicts the answer, runs the access, then updates the model
    task automatic checked_access(input string name, input logic [1:0] op,
                                  input logic [`DMI_ABITS-1:0] addr, input logic [31:0] wdata);
        logic [31:0] exp_data;
        logic [1:0]  exp_status;
        logic [31:0] act_data;
        logic [1:0]  act_status;
        logic        mapped;
        int          idx;
        idx    = int'(addr) - `DMI_DATA_BASE;
        mapped = (idx >= 0) && (idx < `DMI_NDATA);
        if (mapped) begin
            exp_data   = model_data[idx];
            exp_status = ST_OK;
        end else if (addr == `DMI_CNT_ADDR) begin
            // the counter shows its value from before this access
            exp_data   = model_cnt;
            exp_status = ST_OK;
        end else begin
            exp_data   = '0;
            exp_status = ST_FAILED;
        end
        dmi_access(op, addr, wdata, act_data, act_status);
        model_cnt = model_cnt + 32'd1;
        if (mapped && (op == OP_WRITE)) begin
            model_data[idx] = wdata;
        end
        check_value({name, " status"}, 32'(exp_status), 32'(act_status));
        // a mapped write has no defined read data
        if ((op == OP_READ) || !mapped) begin
            check_value({name, " data"}, exp_data, act_data);
        end
    endtask

    task automatic read_all_data(input string name);
        for (int i = 0; i < `DMI_NDATA; i++) begin
            checked_access($sformatf("%s reg %0d", name, i), OP_READ,
                           `DMI_ABITS'(`DMI_DATA_BASE + i), 32'h0);
        end
    endtask

    initial begin
        logic [31:0] r_idx;
        logic [31:0] r_op;
        logic [31:0] r_data;
        logic [31:0] r_addr;
        int          a;
        lfsr_q      = 16'd60537;
        errors      = 0;
        checks      = 0;
        model_cnt   = '0;
        for (int i = 0; i < `DMI_NDATA; i++) begin
            model_data[i] = '0;
        end
        i_nrst      = 1'b0;
        i_tck       = 1'b0;
        i_tdi       = 1'b0;
        i_shift     = 1'b0;
        i_capture   = 1'b0;
        i_update    = 1'b0;
        i_hardreset = 1'b0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        #1;
        i_nrst = 1'b1;
        check_value("reset tdo", 32'h0, 32'(o_tdo));

        // everything reads zero straight out of reset
        checked_access("reset counter", OP_READ, `DMI_ABITS'(`DMI_CNT_ADDR), 32'h0);
        read_all_data("reset");

        // random traffic to the data registers, each access followed by a counter read
        for (int n = 0; n < N_RANDOM; n++) begin
            rand_bits(3, r_idx);
            rand_bits(1, r_op);
            rand_bits(32, r_data);
            checked_access($sformatf("random %0d", n), r_op[0] ? OP_WRITE : OP_READ,
                           `DMI_ABITS'(`DMI_DATA_BASE + r_idx), r_data);
            checked_access("counter", OP_READ, `DMI_ABITS'(`DMI_CNT_ADDR), 32'h0);
        end

        // unmapped addresses skip the data window and the counter
        for (int n = 0; n < N_UNMAPPED; n++) begin
            do begin
                rand_bits(`DMI_ABITS, r_addr);
                a = int'(r_addr);
            end while (((a >= `DMI_DATA_BASE) && (a < `DMI_DATA_BASE + `DMI_NDATA)) ||
                       (a == `DMI_CNT_ADDR));
            rand_bits(1, r_op);
            rand_bits(32, r_data);
            checked_access($sformatf("unmapped %02h", a), r_op[0] ? OP_WRITE : OP_READ,
                           `DMI_ABITS'(a), r_data);
            checked_access("counter", OP_READ, `DMI_ABITS'(`DMI_CNT_ADDR), 32'h0);
        end
        read_all_data("after unmapped");

        // hardreset is held for 20 i_clk cycles while tck keeps sampling it
        i_hardreset = 1'b1;
        tck_pulse();
        tck_pulse();
        repeat (4) @(posedge i_clk);
        #1;
        i_hardreset = 1'b0;
        repeat (2) tck_pulse();
        model_cnt = '0;
        for (int i = 0; i < `DMI_NDATA; i++) begin
            model_data[i] = '0;
        end
        checked_access("hardreset counter", OP_READ, `DMI_ABITS'(`DMI_CNT_ADDR), 32'h0);
        read_all_data("hardreset");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
